/* build.f */
+incdir+.
sha256_pkg.sv
byte_input_fifo.sv
sha256_ctrl.sv
sha256_schedule.sv
sha256_round.sv
streaming_sha256.sv
tb_clock.sv
tb_streaming_sha256.sv

/* run.sh */
#!/bin/sh
# Compile and run the streaming SHA-256 testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_streaming_sha256 -f build.f -o sim_streaming_sha256

output=$(./obj_dir/sim_streaming_sha256)
echo "$output"

# Result comes from the testbench's own report
if echo "$output" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1

/* tb_streaming_sha256.sv */
`timescale 1ns/1ps

module tb_streaming_sha256 import sha256_pkg::*;;

	// Published digests
	localparam digest_t EMPTY_HASH =
		256'he3b0c44298fc1c149afbf4c8996fb92427ae41e4649b934ca495991b7852b855;
	localparam digest_t ABC_HASH =
		256'hba7816bf8f01cfea414140de5dae2223b00361a396177a9cb410ff61f20015ad;
	localparam digest_t ONE_BLOCK_HASH =
		256'h248d6a61d20638b8e5c026930c3e6039a33ce45964ff2167f6ecedd419db06c1;
	localparam digest_t TWO_BLOCK_HASH =
		256'hcf5b16a778af8380036ce59e7b0492370b249b11e8f07a51afac45037afee9d1;
	localparam digest_t FOX_HASH =
		256'hd7a8fbb307d7809469ca9abcb0082e4f8d5651e46d3cdb762d02d0bf37c9e592;

	// Watchdog budget: six messages, up to three blocks each
	// A block costs about 84 hashing cycles plus one cycle per written byte
	localparam int MESSAGES = 6;
	localparam int MAX_BLOCKS = 3;
	localparam int BLOCK_CYCLES = 1 + 17 + 1 + 64 + 1 + 64;
	localparam int TIMEOUT_CYCLES = MESSAGES * MAX_BLOCKS * BLOCK_CYCLES * 8;

	logic       clk;
	logic       reset;
	logic       start;
	logic       update;
	word_t      data_in;
	logic [2:0] bytes_valid;
	logic       finalize;
	logic       ready;
	logic       busy;
	logic       hash_valid;
	digest_t    hash;

	digest_t exp_hash;
	digest_t prev_hash;
	// A finalized message still owes its hash_valid
	logic    waiting;
	int      errors;
	int      msg_count;
	int unsigned seed_val;

	tb_clock u_tb_clock (.clk(clk));

	streaming_sha256 u_streaming_sha256 (
		.clk(clk), .reset(reset),
		.start(start), .update(update), .data_in(data_in), .bytes_valid(bytes_valid),
		.finalize(finalize),
		.ready(ready), .busy(busy), .hash_valid(hash_valid), .hash(hash)
	);

	// Hash seen on the previous edge
	always @(posedge clk) begin
		prev_hash <= hash;
	end

	////////////////////////////////////////
	// Checks
	a_hash_value: assert property (@(posedge clk) disable iff (reset)
		hash_valid |-> hash == exp_hash)
		else begin
			errors++;
			$display("[ERROR] hash: got %h expected %h", $sampled(hash), $sampled(exp_hash));
		end

	a_hash_pulse: assert property (@(posedge clk) disable iff (reset)
		hash_valid |=> !hash_valid)
		else begin
			errors++;
			$display("[ERROR] hash_valid: got %h expected %h after the pulse", 1'b1, 1'b0);
		end

	a_hash_hold: assert property (@(posedge clk) disable iff (reset)
		!hash_valid |-> hash == prev_hash)
		else begin
			errors++;
			$display("[ERROR] hash: got %h expected %h while hash_valid is low",
				$sampled(hash), $sampled(prev_hash));
		end

	a_hash_expected: assert property (@(posedge clk) disable iff (reset)
		hash_valid |-> waiting)
		else begin
			errors++;
			$display("[ERROR] hash_valid: got %h expected %h with no message pending",
				1'b1, 1'b0);
		end

	// Idle state right after reset
	a_busy_after_reset: assert property (@(posedge clk)
		($past(reset) && !reset) |-> !busy)
		else begin
			errors++;
			$display("[ERROR] busy: got %h expected %h after reset", 1'b1, 1'b0);
		end

	a_ready_after_reset: assert property (@(posedge clk)
		($past(reset) && !reset) |-> ready)
		else begin
			errors++;
			$display("[ERROR] ready: got %h expected %h after reset", 1'b0, 1'b1);
		end

	////////////////////////////////////////
	// Stimulus tasks, all on the falling edge
	task automatic wait_idle();
		while (busy) begin
			@(negedge clk);
		end
	endtask

	// Random 1 to 4 byte chunks, first byte in bits 31:24
	task automatic write_bytes(input string msg);
		int    pos;
		int    n;
		int    i;
		word_t w;
		pos = 0;
		while (pos < msg.len()) begin
			n = 1 + int'($urandom % 4);
			if (n > msg.len() - pos) begin
				n = msg.len() - pos;
			end
			w = '0;
			for (i = 0; i < n; i++) begin
				w[31 - 8*i -: 8] = msg[pos + i];
			end
			// Hold off while the FIFO is nearly full
			while (!ready) begin
				update = 1'b0;
				@(negedge clk);
			end
			update      = 1'b1;
			data_in     = w;
			bytes_valid = 3'(n);
			@(negedge clk);
			pos += n;
		end
		update      = 1'b0;
		data_in     = '0;
		bytes_valid = '0;
	endtask

	task automatic hash_message(input string msg, input digest_t expected);
		exp_hash = expected;
		wait_idle();
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		write_bytes(msg);
		// A background block may still be compressing
		wait_idle();
		finalize = 1'b1;
		waiting  = 1'b1;
		@(negedge clk);
		finalize = 1'b0;
		while (!hash_valid) begin
			@(negedge clk);
		end
		@(negedge clk);
		waiting = 1'b0;
		msg_count++;
	endtask

	////////////////////////////////////////
	// Watchdog
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout: the DUT gave no result within %0d cycles", TIMEOUT_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		string block_a;
		string block_b;
		string two_block;
		reset       = 1'b1;
		start       = 1'b0;
		update      = 1'b0;
		data_in     = '0;
		bytes_valid = '0;
		finalize    = 1'b0;
		exp_hash    = '0;
		waiting     = 1'b0;
		errors      = 0;
		msg_count   = 0;
		seed_val    = $urandom(42);
		block_a     = "abcdefghbcdefghicdefghijdefghijkefghijklfghijklmghijklmn";
		block_b     = "hijklmnoijklmnopjklmnopqklmnopqrlmnopqrsmnopqrstnopqrstu";
		two_block   = {block_a, block_b};

		repeat (5) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		// Padding only block
		hash_message("", EMPTY_HASH);
		// Partial last word
		hash_message("abc", ABC_HASH);
		// Length spills into an extra block
		hash_message("abcdbcdecdefdefgefghfghighijhijkijkljklmklmnlmnomnopnopq", ONE_BLOCK_HASH);
		// First block hashed before finalize
		hash_message(two_block, TWO_BLOCK_HASH);
		// Back to back, state must restart cleanly
		hash_message("The quick brown fox jumps over the lazy dog", FOX_HASH);
		hash_message("abc", ABC_HASH);

		repeat (4) @(negedge clk);
		$display("Messages hashed: %0d, errors: %0d", msg_count, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	// 100 ns period
	localparam int HALF_PERIOD_NS = 50;

	initial clk = 1'b0;
	always #(HALF_PERIOD_NS) clk = ~clk;

endmodule

/* streaming_sha256.sv */
`timescale 1ns/1ps

module streaming_sha256 import sha256_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       start,
	input  logic       update,
	input  word_t      data_in,
	input  logic [2:0] bytes_valid,
	input  logic       finalize,
	output logic       ready,
	output logic       busy,
	output logic       hash_valid,
	output digest_t    hash
);

	// FIFO to controller and schedule
	word_t       fifo_dout;
	logic [5:0]  fifo_rsize;
	logic        fifo_rd;

	// Controller strobes
	logic [31:0] msg_len;
	logic        load, clear_tail, pad_marker, pad_length, shift, extend;
	logic [3:0]  load_index;
	logic        init, save, step, accumulate;
	logic [5:0]  round;

	word_t       w_cur;
	digest_t     digest;
	// Last reported digest
	digest_t     hash_q;

	byte_input_fifo u_byte_input_fifo (
		.clk(clk), .reset(reset),
		.wr(update), .din(data_in), .bytes_valid(bytes_valid), .flush(finalize),
		.rd(fifo_rd), .dout(fifo_dout), .rsize(fifo_rsize), .ready(ready)
	);

	sha256_ctrl u_sha256_ctrl (
		.clk(clk), .reset(reset),
		.start(start), .finalize(finalize), .update(update), .bytes_valid(bytes_valid),
		.fifo_rsize(fifo_rsize), .fifo_rd(fifo_rd),
		.busy(busy), .hash_valid(hash_valid), .msg_len(msg_len),
		.load(load), .load_index(load_index), .clear_tail(clear_tail),
		.pad_marker(pad_marker), .pad_length(pad_length),
		.shift(shift), .extend(extend),
		.init(init), .save(save), .step(step), .accumulate(accumulate), .round(round)
	);

	sha256_schedule u_sha256_schedule (
		.clk(clk), .reset(reset),
		.load(load), .load_index(load_index), .din(fifo_dout), .clear_tail(clear_tail),
		.pad_marker(pad_marker), .pad_length(pad_length), .msg_len(msg_len),
		.shift(shift), .extend(extend), .w_cur(w_cur)
	);

	sha256_round u_sha256_round (
		.clk(clk), .reset(reset),
		.init(init), .save(save), .step(step), .accumulate(accumulate),
		.round(round), .w_cur(w_cur), .digest(digest)
	);

	// Digest is stable through the hash_valid cycle, capture it there
	always_ff @(posedge clk) begin
		if (reset) begin
			hash_q <= '0;
		end else if (hash_valid) begin
			hash_q <= digest;
		end
	end

	// New value shows up with the pulse and holds until the next one
	assign hash = hash_valid ? digest : hash_q;

endmodule

/* sha256_round.sv */
`timescale 1ns/1ps
`include "sha256_defs.svh"

module sha256_round import sha256_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       init,
	input  logic       save,
	input  logic       step,
	input  logic       accumulate,
	input  logic [5:0] round,
	input  word_t      w_cur,
	output digest_t    digest
);

	// Initial hash value H0..H7
	localparam digest_t IV = {32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19};

	////////////////////////////////////////
	// Round constants
	localparam word_t K [`SHA256_ROUNDS] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// Working variables
	word_t a, b, c, d, e, f, g, h;
	// Chaining value from the start of the block
	digest_t saved;
	word_t big_s0, big_s1, ch, maj, t1, t2;

	assign digest = {a, b, c, d, e, f, g, h};

	// One compression round
	always_comb begin
		big_s1 = rotr(e, 6) ^ rotr(e, 11) ^ rotr(e, 25);
		ch     = (e & f) ^ (~e & g);
		t1     = h + big_s1 + ch + K[round] + w_cur;
		big_s0 = rotr(a, 2) ^ rotr(a, 13) ^ rotr(a, 22);
		maj    = (a & b) ^ (a & c) ^ (b & c);
		t2     = big_s0 + maj;
	end

	always_ff @(posedge clk) begin
		if (reset || init) begin
			{a, b, c, d, e, f, g, h} <= IV;
		end else if (step) begin
			{a, b, c, d} <= {t1 + t2, a, b, c};
			{e, f, g, h} <= {d + t1, e, f, g};
		end else if (accumulate) begin
			// Feed forward of the block's input state
			a <= a + saved[255:224];
			b <= b + saved[223:192];
			c <= c + saved[191:160];
			d <= d + saved[159:128];
			e <= e + saved[127:96];
			f <= f + saved[95:64];
			g <= g + saved[63:32];
			h <= h + saved[31:0];
		end
	end

	always_ff @(posedge clk) begin
		if (save) begin
			saved <= digest;
		end
	end

endmodule

/* sha256_schedule.sv */
`timescale 1ns/1ps

module sha256_schedule import sha256_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        load,
	input  logic [3:0]  load_index,
	input  word_t       din,
	input  logic        clear_tail,
	input  logic        pad_marker,
	input  logic        pad_length,
	input  logic [31:0] msg_len,
	input  logic        shift,
	input  logic        extend,
	output word_t       w_cur
);

	// Sliding window, w[0] is W[t] for the current round
	word_t w [16];
	word_t s0;
	word_t s1;
	word_t w_next;
	word_t marker;
	logic [3:0] pad_word;

	assign pad_word = msg_len[5:2];
	assign w_cur = w[0];

	// W[t+16] from W[t], W[t+1], W[t+9], W[t+14]
	always_comb begin
		s0 = rotr(w[1], 7) ^ rotr(w[1], 18) ^ (w[1] >> 3);
		s1 = rotr(w[14], 17) ^ rotr(w[14], 19) ^ (w[14] >> 10);
		w_next = w[0] + s0 + w[9] + s1;
	end

	// 0x80 right after the last message byte, lower bytes cleared
	always_comb begin
		case (msg_len[1:0])
			2'd0: marker = 32'h8000_0000;
			2'd1: marker = {w[pad_word][31:24], 24'h80_0000};
			2'd2: marker = {w[pad_word][31:16], 16'h8000};
			default: marker = {w[pad_word][31:8], 8'h80};
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++) begin
				w[i] <= '0;
			end
		end else begin
			if (load) begin
				w[load_index] <= din;
			end
			// Slots from load_index upward were never filled
			if (clear_tail) begin
				for (int i = 0; i < 16; i++) begin
					if (4'(i) >= load_index) begin
						w[i] <= '0;
					end
				end
			end
			if (pad_marker) begin
				w[pad_word] <= marker;
			end
			// Bit length, big endian over slots 14 and 15
			if (pad_length) begin
				w[14] <= {29'h0, msg_len[31:29]};
				w[15] <= {msg_len[28:0], 3'b000};
			end
			if (shift) begin
				for (int i = 0; i < 15; i++) begin
					w[i] <= w[i + 1];
				end
				w[15] <= extend ? w_next : '0;
			end
		end
	end

endmodule

/* sha256_ctrl.sv */
`timescale 1ns/1ps
`include "sha256_defs.svh"

module sha256_ctrl import sha256_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        start,
	input  logic        finalize,
	input  logic        update,
	input  logic [2:0]  bytes_valid,
	input  logic [5:0]  fifo_rsize,
	output logic        fifo_rd,
	output logic        busy,
	output logic        hash_valid,
	output logic [31:0] msg_len,
	output logic        load,
	output logic [3:0]  load_index,
	output logic        clear_tail,
	output logic        pad_marker,
	output logic        pad_length,
	output logic        shift,
	output logic        extend,
	output logic        init,
	output logic        save,
	output logic        step,
	output logic        accumulate,
	output logic [5:0]  round
);

	ctrl_state_t state;
	// Words stored into W so far this block
	logic [3:0] wr_count;
	// FIFO output is valid one cycle after rd
	logic rd_q;
	logic finalizing;
	// 0x80 already placed in an earlier block
	logic marker_done;
	logic last_block;
	logic block_ready;
	logic fits;

	// 16 complete words waiting and a partial word does not count
	assign block_ready = (fifo_rsize > 6'd16) ||
		((fifo_rsize == 6'd16) && (msg_len[1:0] == 2'b00));
	// Marker and 64-bit length share the last data block
	assign fits = msg_len[5:0] <= 6'd55;

	////////////////////////////////////////
	// Message length in bytes
	always_ff @(posedge clk) begin
		if (reset) begin
			msg_len <= '0;
		end else if (start) begin
			msg_len <= '0;
		end else if (update) begin
			msg_len <= msg_len + 32'(bytes_valid);
		end
	end

	////////////////////////////////////////
	// Block FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= IDLE;
			fifo_rd     <= 1'b0;
			rd_q        <= 1'b0;
			hash_valid  <= 1'b0;
			wr_count    <= '0;
			round       <= '0;
			finalizing  <= 1'b0;
			marker_done <= 1'b0;
			last_block  <= 1'b0;
		end else begin
			fifo_rd    <= 1'b0;
			hash_valid <= 1'b0;
			rd_q       <= fifo_rd;
			case (state)
				IDLE: begin
					// Finalize wins over a background block
					if (finalize) begin
						finalizing <= 1'b1;
						wr_count   <= '0;
						fifo_rd    <= fifo_rsize != 6'd0;
						state      <= READ_PIPE;
					end else if (block_ready) begin
						wr_count <= '0;
						fifo_rd  <= 1'b1;
						state    <= READ_PIPE;
					end
				end
				READ_PIPE: begin
					// More on top of the word now being read
					fifo_rd <= fifo_rsize > 6'd1;
					round   <= '0;
					state   <= FILL_W;
				end
				FILL_W: begin
					if (rd_q) begin
						wr_count <= wr_count + 4'd1;
						if (wr_count == 4'd15) begin
							// A closing partial word in slot 15 still takes the 0x80 byte
							if (finalizing && (fifo_rsize == 6'd0) &&
								(msg_len[1:0] != 2'b00)) begin
								state <= PAD;
							end else begin
								state <= COMPRESS;
							end
						end else if ((fifo_rsize > 6'd1) && (wr_count < 4'd14)) begin
							fifo_rd <= 1'b1;
						end
					end else if (fifo_rsize == 6'd0) begin
						// Message exhausted so the tail is zeroed this cycle
						state <= PAD;
					end
				end
				PAD: begin
					if (marker_done || fits) begin
						last_block <= 1'b1;
					end else begin
						marker_done <= 1'b1;
					end
					state <= COMPRESS;
				end
				COMPRESS: begin
					round <= round + 6'd1;
					if (round == 6'(`SHA256_ROUNDS - 1)) begin
						state <= BLOCK_DONE;
					end
				end
				BLOCK_DONE: begin
					if (last_block) begin
						state <= DONE;
					end else if (finalizing) begin
						// Second data block or the length-only block
						wr_count <= '0;
						fifo_rd  <= fifo_rsize != 6'd0;
						state    <= READ_PIPE;
					end else begin
						state <= IDLE;
					end
				end
				DONE: begin
					hash_valid  <= 1'b1;
					finalizing  <= 1'b0;
					marker_done <= 1'b0;
					last_block  <= 1'b0;
					state       <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Held through the hash_valid cycle
	assign busy = (state != IDLE) || hash_valid;

	// Datapath strobes decoded from the state
	assign load       = (state == FILL_W) && rd_q;
	assign load_index = wr_count;
	assign clear_tail = (state == FILL_W) && !rd_q && (fifo_rsize == 6'd0);
	assign pad_marker = (state == PAD) && !marker_done;
	assign pad_length = (state == PAD) && (marker_done || fits);
	assign shift      = state == COMPRESS;
	assign step       = state == COMPRESS;
	assign extend     = (state == COMPRESS) && (round < 6'(`SHA256_EXTEND_ROUNDS));
	assign init       = (state == IDLE) && start;
	assign save       = state == READ_PIPE;
	assign accumulate = state == BLOCK_DONE;

	// Host strobes only while the core is free
	a_host_idle: assert property (@(posedge clk) disable iff (reset)
		(start || finalize) |-> !busy)
		else $error("start or finalize while busy");

endmodule

/* byte_input_fifo.sv */
`timescale 1ns/1ps
`include "sha256_defs.svh"

module byte_input_fifo import sha256_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       wr,
	input  word_t      din,
	input  logic [2:0] bytes_valid,
	input  logic       flush,
	input  logic       rd,
	output word_t      dout,
	output logic [5:0] rsize,
	output logic       ready
);

	localparam int PTR_W = $clog2(`SHA256_FIFO_BYTES);

	// Circular byte store
	logic [7:0] mem [`SHA256_FIFO_BYTES];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	// Bytes held, 0 up to the full capacity
	logic [PTR_W:0] count;
	logic [PTR_W:0] free;

	// Bytes entering this cycle and where they come from
	logic [2:0] n_in;
	logic [2:0] pad_n;
	word_t      wbytes;

	// Zero bytes that close a partial word on flush
	assign pad_n = flush ? {1'b0, ~wr_ptr[1:0] + 2'd1} : 3'd0;
	assign n_in = wr ? bytes_valid : pad_n;
	assign wbytes = wr ? din : '0;

	// Complete words, plus one for a partial word
	assign rsize = count[PTR_W:2] + {{(PTR_W-2){1'b0}}, |count[1:0]};
	assign free = (PTR_W+1)'(`SHA256_FIFO_BYTES) - count;
	assign ready = free >= (PTR_W+1)'(`SHA256_FREE_MIN);

	////////////////////////////////////////
	// Write side, first byte from bits 31:24
	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (3'(i) < n_in) begin
				mem[wr_ptr + PTR_W'(i)] <= wbytes[31 - 8*i -: 8];
			end
		end
	end

	// Registered big-endian read word
	always_ff @(posedge clk) begin
		if (rd) begin
			dout <= {mem[rd_ptr], mem[rd_ptr + PTR_W'(1)],
				mem[rd_ptr + PTR_W'(2)], mem[rd_ptr + PTR_W'(3)]};
		end
	end

	////////////////////////////////////////
	// Pointers and fill level
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			wr_ptr <= wr_ptr + PTR_W'(n_in);
			// Reads are always whole words, so rd_ptr stays word aligned
			if (rd) begin
				rd_ptr <= rd_ptr + PTR_W'(4);
			end
			count <= count + (PTR_W+1)'(n_in) - (rd ? (PTR_W+1)'(4) : '0);
		end
	end

	// Host must respect back-pressure
	a_no_overflow: assert property (@(posedge clk) disable iff (reset) wr |-> ready)
		else $error("write while FIFO not ready");

	// Controller only pops words that exist
	a_no_underflow: assert property (@(posedge clk) disable iff (reset) rd |-> rsize != 6'd0)
		else $error("read from empty FIFO");

endmodule

/* sha256_pkg.sv */
package sha256_pkg;

	// One SHA-256 word
	typedef logic [31:0] word_t;

	// H0 in bits 255:224, H7 in bits 31:0
	typedef logic [255:0] digest_t;

	// Block level controller states
	typedef enum logic [2:0] {
		IDLE,
		READ_PIPE,
		FILL_W,
		PAD,
		COMPRESS,
		BLOCK_DONE,
		DONE
	} ctrl_state_t;

	// Rotate right, used by both the schedule and the round logic
	function automatic word_t rotr(word_t x, int unsigned n);
		return (x >> n) | (x << (32 - n));
	endfunction

endpackage

/* sha256_defs.svh */
`ifndef SHA256_DEFS_SVH
`define SHA256_DEFS_SVH

// Input FIFO capacity in bytes, room for two message blocks
`define SHA256_FIFO_BYTES 128

// Compression rounds per 64-byte block
`define SHA256_ROUNDS 64

// Rounds below this one append a freshly extended W word
`define SHA256_EXTEND_ROUNDS 48

// Host is held off once fewer bytes than one full write are free
`define SHA256_FREE_MIN 4

`endif
